// File: hw/mcoi_cfg.svh
`ifndef MCOI_CFG_SVH
`define MCOI_CFG_SVH

// ----------------------------------------
// system sizing
// ----------------------------------------

// motors served over one fiber
`define MCOI_MOTORS 16

// one stream word per clk40m, slow-control bits excluded
`define MCOI_STREAM_W 80

// ----------------------------------------
// input conditioning
// ----------------------------------------

// stable samples needed before a debounced input flips
`define MCOI_DEB_CYCLES 8

`endif

// File: hw/mcoi_pkg.sv
`default_nettype none
`include "mcoi_cfg.svh"

package mcoi_pkg;

    // ----------------------------------------
    // frame layout
    // ----------------------------------------

    // motor index field, 4 bits for 16 motors
    localparam int MOTOR_W = $clog2(`MCOI_MOTORS);
    // what is left after op and motor index
    localparam int PAYLOAD_W = `MCOI_STREAM_W - 4 - MOTOR_W;
    // unused upper bits of the two reply payloads
    localparam int RSVD_MOT_W = PAYLOAD_W - 7;
    localparam int RSVD_ALL_W = PAYLOAD_W - 3 * `MCOI_MOTORS;

    // stream opcodes, sit in the top nibble of a frame
    typedef enum logic [3:0] {
        OP_NOP       = 4'h0,
        OP_SET_CTRL  = 4'h1,
        OP_GET_MOTOR = 4'h2,
        OP_GET_ALL   = 4'h3
    } mcoi_op_e;

    typedef struct packed {
        mcoi_op_e             op;
        logic [MOTOR_W-1:0]   motor;
        logic [PAYLOAD_W-1:0] payload;
    } mcoi_frame_t;

    // ----------------------------------------
    // per-motor lanes
    // ----------------------------------------

    // step is bit 0, matches payload[3:0] of a write
    typedef struct packed {
        logic boost;
        logic dir;
        logic deactivate;
        logic step;
    } motor_ctrl_t;

    typedef struct packed {
        logic pfail;
        logic sw_a;
        logic sw_b;
    } motor_stat_t;

    // one entry per motor, index = motor number
    typedef motor_ctrl_t [`MCOI_MOTORS-1:0] motor_ctrl_arr_t;
    typedef motor_stat_t [`MCOI_MOTORS-1:0] motor_stat_arr_t;

    // GET_MOTOR reply payload
    typedef struct packed {
        logic [RSVD_MOT_W-1:0] rsvd;
        motor_stat_t           stat;
        motor_ctrl_t           ctrl;
    } motor_reply_t;

    // GET_ALL reply payload, bit n of each vector is motor n
    typedef struct packed {
        logic [RSVD_ALL_W-1:0]   rsvd;
        logic [`MCOI_MOTORS-1:0] pfail;
        logic [`MCOI_MOTORS-1:0] sw_b;
        logic [`MCOI_MOTORS-1:0] sw_a;
    } all_reply_t;

    // motors come up switched off
    localparam motor_ctrl_t CTRL_RESET = '{boost: 1'b0, dir: 1'b0,
                                           deactivate: 1'b1, step: 1'b0};

endpackage

`default_nettype wire

// File: hw/motor_pingroup.sv
`timescale 1ns/1ps
`default_nettype none
`include "mcoi_cfg.svh"

module motor_pingroup
    import mcoi_pkg::*;
(
    input  logic                    clk40m,
    input  logic                    rst_n,

    // control from mcoi_base, step already blocked
    input  motor_ctrl_arr_t         ctrl,
    // debounced pin state back to mcoi_base
    output motor_stat_arr_t         stat,

    // motor driver pins
    output logic [`MCOI_MOTORS-1:0] pl_boost,
    output logic [`MCOI_MOTORS-1:0] pl_dir,
    output logic [`MCOI_MOTORS-1:0] pl_en,
    output logic [`MCOI_MOTORS-1:0] pl_clk,
    input  logic [`MCOI_MOTORS-1:0] pl_pfail,
    input  logic [`MCOI_MOTORS-1:0] pl_sw_outa,
    input  logic [`MCOI_MOTORS-1:0] pl_sw_outb
);

    // sw_b lanes low, then sw_a, pfail on top
    localparam int RAW_W = 3 * `MCOI_MOTORS;
    // counter must hold MCOI_DEB_CYCLES-1
    localparam int CNT_W = $clog2(`MCOI_DEB_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`MCOI_DEB_CYCLES - 1);

    logic [RAW_W-1:0] raw;
    logic [RAW_W-1:0] sync_1;
    logic [RAW_W-1:0] sync_2;
    logic [RAW_W-1:0] deb;
    logic [CNT_W-1:0] deb_cnt [RAW_W];

    // ----------------------------------------
    // output pins
    // ----------------------------------------

    // one register stage, pins follow ctrl one clock late
    always_ff @(posedge clk40m or negedge rst_n) begin
        if (!rst_n) begin
            pl_boost <= '0;
            pl_dir   <= '0;
            // drivers held off
            pl_en    <= '1;
            pl_clk   <= '0;
        end else begin
            for (int i = 0; i < `MCOI_MOTORS; i++) begin
                pl_boost[i] <= ctrl[i].boost;
                pl_dir[i]   <= ctrl[i].dir;
                // pl_en high = driver deactivated
                pl_en[i]    <= ctrl[i].deactivate;
                pl_clk[i]   <= ctrl[i].step;
            end
        end
    end

    // ----------------------------------------
    // input synchronizers
    // ----------------------------------------

    // all raw inputs packed into one bus
    assign raw = {pl_pfail, pl_sw_outa, pl_sw_outb};

    // switches and pfail are async to clk40m
    always_ff @(posedge clk40m or negedge rst_n) begin
        if (!rst_n) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= raw;
            sync_2 <= sync_1;
        end
    end

    // ----------------------------------------
    // debounce
    // ----------------------------------------

    // counts samples that differ from the debounced value
    // any agreeing sample restarts the count
    always_ff @(posedge clk40m or negedge rst_n) begin
        if (!rst_n) begin
            deb <= '0;
            for (int i = 0; i < RAW_W; i++) begin
                deb_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RAW_W; i++) begin
                if (sync_2[i] == deb[i]) begin
                    deb_cnt[i] <= '0;
                end else if (deb_cnt[i] == CNT_LAST) begin
                    // enough stable samples, take the new level
                    deb[i]     <= sync_2[i];
                    deb_cnt[i] <= '0;
                end else begin
                    deb_cnt[i] <= deb_cnt[i] + 1'b1;
                end
            end
        end
    end

    // back into per-motor status words
    always_comb begin
        for (int i = 0; i < `MCOI_MOTORS; i++) begin
            stat[i].sw_b  = deb[i];
            stat[i].sw_a  = deb[`MCOI_MOTORS + i];
            stat[i].pfail = deb[2 * `MCOI_MOTORS + i];
        end
    end

endmodule

`default_nettype wire

// File: hw/mcoi_base.sv
`timescale 1ns/1ps
`default_nettype none
`include "mcoi_cfg.svh"

module mcoi_base
    import mcoi_pkg::*;
(
    input  logic            clk40m,
    input  logic            rst_n,

    // stream side, one frame each clock
    input  mcoi_frame_t     frame_in,
    output mcoi_frame_t     frame_out,

    // pin group side
    input  motor_stat_arr_t stat,
    output motor_ctrl_arr_t ctrl
);

    // stored control words, as written
    motor_ctrl_arr_t ctrl_q;

    // decode results
    logic        set_en;
    mcoi_frame_t reply_d;

    // reply payload builders
    motor_reply_t mot_rep;
    all_reply_t   all_rep;

    // status regrouped as one bit per motor
    logic [`MCOI_MOTORS-1:0] sw_a_vec;
    logic [`MCOI_MOTORS-1:0] sw_b_vec;
    logic [`MCOI_MOTORS-1:0] pfail_vec;

    // step blocked by end switch or power fail
    logic [`MCOI_MOTORS-1:0] step_block;

    // ----------------------------------------
    // status gathering
    // ----------------------------------------

    always_comb begin
        for (int i = 0; i < `MCOI_MOTORS; i++) begin
            sw_a_vec[i]  = stat[i].sw_a;
            sw_b_vec[i]  = stat[i].sw_b;
            pfail_vec[i] = stat[i].pfail;
        end
    end

    // ----------------------------------------
    // frame decode
    // ----------------------------------------

    always_comb begin
        // addressed motor, stored word and live status
        mot_rep      = '0;
        mot_rep.ctrl = ctrl_q[frame_in.motor];
        mot_rep.stat = stat[frame_in.motor];

        // every motor at once, no control words
        all_rep       = '0;
        all_rep.sw_a  = sw_a_vec;
        all_rep.sw_b  = sw_b_vec;
        all_rep.pfail = pfail_vec;

        set_en  = 1'b0;
        reply_d = '0;

        case (frame_in.op)
            OP_SET_CTRL: begin
                // write only, reply stays zero
                set_en = 1'b1;
            end
            OP_GET_MOTOR: begin
                reply_d.op      = OP_GET_MOTOR;
                reply_d.motor   = frame_in.motor;
                reply_d.payload = mot_rep;
            end
            OP_GET_ALL: begin
                reply_d.op      = OP_GET_ALL;
                reply_d.motor   = frame_in.motor;
                reply_d.payload = all_rep;
            end
            // nop and unknown codes
            default: begin
                reply_d = '0;
            end
        endcase
    end

    // ----------------------------------------
    // control registers
    // ----------------------------------------

    always_ff @(posedge clk40m or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MCOI_MOTORS; i++) begin
                ctrl_q[i] <= CTRL_RESET;
            end
        end else if (set_en) begin
            // low nibble of payload is the new word
            ctrl_q[frame_in.motor] <= motor_ctrl_t'(frame_in.payload[3:0]);
        end
    end

    // reply one clock after the request
    always_ff @(posedge clk40m or negedge rst_n) begin
        if (!rst_n) begin
            frame_out <= '0;
        end else begin
            frame_out <= reply_d;
        end
    end

    // ----------------------------------------
    // limit switch blocking
    // ----------------------------------------

    // dir 1 runs towards switch a, dir 0 towards switch b
    always_comb begin
        for (int i = 0; i < `MCOI_MOTORS; i++) begin
            step_block[i] = pfail_vec[i]
                          | (ctrl_q[i].dir & sw_a_vec[i])
                          | (~ctrl_q[i].dir & sw_b_vec[i]);
        end
    end

    // only the outgoing step is gated, stored word untouched
    always_comb begin
        for (int i = 0; i < `MCOI_MOTORS; i++) begin
            ctrl[i]      = ctrl_q[i];
            ctrl[i].step = ctrl_q[i].step & ~step_block[i];
        end
    end

endmodule

`default_nettype wire

// File: hw/mcoi_xu5_design_complet.sv
`timescale 1ns/1ps
`default_nettype none
`include "mcoi_cfg.svh"

module mcoi_xu5_design_complet
    import mcoi_pkg::*;
(
    input  logic                    clk40m,
    input  logic                    rst_n,

    // optical stream, link layer lives outside
    input  mcoi_frame_t             frame_in,
    output mcoi_frame_t             frame_out,

    // motors
    output logic [`MCOI_MOTORS-1:0] pl_boost,
    output logic [`MCOI_MOTORS-1:0] pl_dir,
    output logic [`MCOI_MOTORS-1:0] pl_en,
    output logic [`MCOI_MOTORS-1:0] pl_clk,
    input  logic [`MCOI_MOTORS-1:0] pl_pfail,
    input  logic [`MCOI_MOTORS-1:0] pl_sw_outa,
    input  logic [`MCOI_MOTORS-1:0] pl_sw_outb
);

    // ----------------------------------------
    // lanes between decoder and pins
    // ----------------------------------------

    // blocked control words towards the pins
    motor_ctrl_arr_t motor_ctrl;
    // debounced switch and pfail state
    motor_stat_arr_t motor_stat;

    // frame decode and control storage
    mcoi_base i_mcoi_base (
        .clk40m    (clk40m),
        .rst_n     (rst_n),
        .frame_in  (frame_in),
        .frame_out (frame_out),
        .stat      (motor_stat),
        .ctrl      (motor_ctrl)
    );

    // pin registers and input conditioning
    motor_pingroup i_pg_motors (
        .clk40m     (clk40m),
        .rst_n      (rst_n),
        .ctrl       (motor_ctrl),
        .stat       (motor_stat),
        .pl_boost   (pl_boost),
        .pl_dir     (pl_dir),
        .pl_en      (pl_en),
        .pl_clk     (pl_clk),
        .pl_pfail   (pl_pfail),
        .pl_sw_outa (pl_sw_outa),
        .pl_sw_outb (pl_sw_outb)
    );

endmodule

`default_nettype wire

// File: sim/tb_mcoi.sv
`timescale 1ns/1ps
`default_nettype none
`include "mcoi_cfg.svh"

module tb_mcoi
    import mcoi_pkg::*;
();

    // ----------------------------------------
    // trace format
    // ----------------------------------------

    localparam int TRACE_DEPTH = 128;
    // GET_ALL polls before a debounce wait gives up
    localparam int DEB_TIMEOUT = 40;
    localparam int RAND_SEED = 51958;

    // step kinds, first hex digit of a trace line
    localparam logic [3:0] STEP_END      = 4'h0;
    localparam logic [3:0] STEP_FRAME    = 4'h1;
    localparam logic [3:0] STEP_PINS     = 4'h2;
    localparam logic [3:0] STEP_IDLE     = 4'h4;
    localparam logic [3:0] STEP_WAIT_ALL = 4'h5;
    localparam logic [3:0] STEP_PIN_ONE  = 4'h6;
    localparam logic [3:0] STEP_RAND_SET = 4'h7;
    localparam logic [3:0] STEP_STAT     = 4'h8;
    localparam logic [3:0] STEP_PIN_ALL  = 4'h9;
    localparam logic [3:0] STEP_TEST_END = 4'he;

    typedef struct packed {
        logic [3:0]                kind;
        logic [3:0]                motor;
        mcoi_frame_t               stim;
        logic [`MCOI_STREAM_W-1:0] exp_val;
    } trace_rec_t;

    logic [$bits(trace_rec_t)-1:0] trace_mem [TRACE_DEPTH];

    logic                    clk40m;
    logic                    rst_n;
    mcoi_frame_t             frame_in;
    mcoi_frame_t             frame_out;
    logic [`MCOI_MOTORS-1:0] pl_boost;
    logic [`MCOI_MOTORS-1:0] pl_dir;
    logic [`MCOI_MOTORS-1:0] pl_en;
    logic [`MCOI_MOTORS-1:0] pl_clk;
    logic [`MCOI_MOTORS-1:0] pl_pfail;
    logic [`MCOI_MOTORS-1:0] pl_sw_outa;
    logic [`MCOI_MOTORS-1:0] pl_sw_outb;

    // what the board should hold, per motor
    motor_ctrl_t model_ctrl [`MCOI_MOTORS];
    motor_stat_t model_stat [`MCOI_MOTORS];

    int    test_checks;
    int    test_errors;
    int    total_checks;
    int    total_errors;
    string test_name [16];

    mcoi_xu5_design_complet UUT (
        .clk40m     (clk40m),
        .rst_n      (rst_n),
        .frame_in   (frame_in),
        .frame_out  (frame_out),
        .pl_boost   (pl_boost),
        .pl_dir     (pl_dir),
        .pl_en      (pl_en),
        .pl_clk     (pl_clk),
        .pl_pfail   (pl_pfail),
        .pl_sw_outa (pl_sw_outa),
        .pl_sw_outb (pl_sw_outb)
    );

    // 8 ns period
    initial clk40m = 1'b0;
    always #4 clk40m = ~clk40m;

    // ----------------------------------------
    // helpers and compares
    // ----------------------------------------

    // one full clock, ends on the falling edge where inputs change
    task automatic next_cycle();
        @(posedge clk40m);
        @(negedge clk40m);
    endtask

    task automatic check_frame(input string name, input mcoi_frame_t exp_f,
                               input mcoi_frame_t act);
        test_checks++;
        if (act !== exp_f) begin
            test_errors++;
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp_f, act);
        end
    endtask

    task automatic check_ctrl_pins(input int m, input motor_ctrl_t exp_c);
        motor_ctrl_t act;
        act.boost      = pl_boost[m];
        act.dir        = pl_dir[m];
        act.deactivate = pl_en[m];
        act.step       = pl_clk[m];
        test_checks++;
        if (act !== exp_c) begin
            test_errors++;
            $display("MISMATCH t=%0t pins of motor %0d expected %h actual %h",
                     $time, m, exp_c, act);
        end
    endtask

    task automatic check_stat(input int m, input motor_stat_t exp_s, input motor_stat_t act);
        test_checks++;
        if (act !== exp_s) begin
            test_errors++;
            $display("MISMATCH t=%0t status of motor %0d expected %h actual %h",
                     $time, m, exp_s, act);
        end
    endtask

    // stored word, step dropped when running into an active end switch or on pfail
    function automatic motor_ctrl_t expected_pins(input int m);
        motor_ctrl_t c;
        logic        block;
        c     = model_ctrl[m];
        block = model_stat[m].pfail | (c.dir & model_stat[m].sw_a)
              | (!c.dir & model_stat[m].sw_b);
        c.step = c.step & !block;
        return c;
    endfunction

    // GET_ALL reply for motor 0 built from the model status
    function automatic mcoi_frame_t expected_all();
        mcoi_frame_t f;
        f    = '0;
        f.op = OP_GET_ALL;
        for (int i = 0; i < `MCOI_MOTORS; i++) begin
            f.payload[i]                    = model_stat[i].sw_a;
            f.payload[`MCOI_MOTORS + i]     = model_stat[i].sw_b;
            f.payload[2 * `MCOI_MOTORS + i] = model_stat[i].pfail;
        end
        return f;
    endfunction

    // same bit layout as a GET_ALL payload
    task automatic drive_pins(input logic [`MCOI_STREAM_W-1:0] v);
        pl_sw_outa = v[15:0];
        pl_sw_outb = v[31:16];
        pl_pfail   = v[47:32];
    endtask

    task automatic write_random(input logic [3:0] m);
        logic [31:0] bits;
        mcoi_frame_t req;
        bits          = $urandom();
        req           = '0;
        req.op        = OP_SET_CTRL;
        req.motor     = m;
        req.payload[3:0] = bits[3:0];
        frame_in = req;
        next_cycle();
        frame_in = '0;
        model_ctrl[m] = motor_ctrl_t'(bits[3:0]);
        check_frame("frame_out after random write", '0, frame_out);
        next_cycle();
        check_ctrl_pins(int'(m), expected_pins(int'(m)));
    endtask

    // idle cycles poll GET_ALL, debounced status must not move
    task automatic idle_poll(input int cycles);
        mcoi_frame_t req;
        req    = '0;
        req.op = OP_GET_ALL;
        for (int n = 0; n < cycles; n++) begin
            frame_in = req;
            next_cycle();
            check_frame("frame_out while idle", expected_all(), frame_out);
        end
        frame_in = '0;
    endtask

    // poll GET_ALL until the debounced vectors arrive
    task automatic wait_status(input trace_rec_t rec);
        int          tries;
        logic        matched;
        mcoi_frame_t exp_f;
        exp_f   = mcoi_frame_t'(rec.exp_val);
        matched = 1'b0;
        tries   = 0;
        while (!matched && tries < DEB_TIMEOUT) begin
            frame_in = rec.stim;
            next_cycle();
            matched = (frame_out === exp_f);
            tries++;
        end
        frame_in = '0;
        test_checks++;
        if (matched) begin
            for (int i = 0; i < `MCOI_MOTORS; i++) begin
                model_stat[i].sw_a  = exp_f.payload[i];
                model_stat[i].sw_b  = exp_f.payload[`MCOI_MOTORS + i];
                model_stat[i].pfail = exp_f.payload[2 * `MCOI_MOTORS + i];
            end
        end else begin
            test_errors++;
            $display("ERROR t=%0t debounced status never reached %h within %0d polls",
                     $time, exp_f, DEB_TIMEOUT);
        end
    endtask

    task automatic read_stat(input logic [3:0] m, input motor_stat_t exp_s);
        mcoi_frame_t req;
        req       = '0;
        req.op    = OP_GET_MOTOR;
        req.motor = m;
        frame_in  = req;
        next_cycle();
        frame_in = '0;
        check_stat(int'(m), exp_s, motor_stat_t'(frame_out.payload[6:4]));
    endtask

    // ----------------------------------------
    // trace player
    // ----------------------------------------

    initial begin
        int         idx;
        logic       done;
        trace_rec_t rec;
        void'($urandom(RAND_SEED));
        test_name[1] = "reset state";
        test_name[2] = "control writes";
        test_name[3] = "readback";
        test_name[4] = "debounce";
        test_name[5] = "limit blocking";
        test_checks  = 0;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        for (int i = 0; i < TRACE_DEPTH; i++) begin
            trace_mem[i] = '0;
        end
        $readmemh("sim/mcoi_trace.txt", trace_mem);
        for (int i = 0; i < `MCOI_MOTORS; i++) begin
            model_ctrl[i] = CTRL_RESET;
            model_stat[i] = '0;
        end
        rst_n    = 1'b0;
        frame_in = '0;
        drive_pins('0);
        repeat (4) @(posedge clk40m);
        @(negedge clk40m);
        // reset values, seen while reset is still held
        check_frame("frame_out in reset", '0, frame_out);
        for (int i = 0; i < `MCOI_MOTORS; i++) begin
            check_ctrl_pins(i, expected_pins(i));
        end
        rst_n = 1'b1;
        idx   = 0;
        done  = 1'b0;
        while (!done && idx < TRACE_DEPTH) begin
            rec = trace_rec_t'(trace_mem[idx]);
            idx++;
            frame_in = '0;
            case (rec.kind)
                STEP_END: done = 1'b1;
                STEP_FRAME: begin
                    frame_in = rec.stim;
                    next_cycle();
                    if (rec.stim.op == OP_SET_CTRL) begin
                        model_ctrl[rec.stim.motor] = motor_ctrl_t'(rec.stim.payload[3:0]);
                    end
                    check_frame("frame_out", mcoi_frame_t'(rec.exp_val), frame_out);
                end
                STEP_PINS: begin
                    drive_pins(rec.stim);
                    next_cycle();
                end
                STEP_IDLE: idle_poll(int'(rec.exp_val[7:0]));
                STEP_WAIT_ALL: wait_status(rec);
                STEP_PIN_ONE: begin
                    next_cycle();
                    check_ctrl_pins(int'(rec.motor), motor_ctrl_t'(rec.exp_val[3:0]));
                end
                STEP_RAND_SET: write_random(rec.motor);
                STEP_STAT: read_stat(rec.motor, motor_stat_t'(rec.exp_val[2:0]));
                STEP_PIN_ALL: begin
                    next_cycle();
                    for (int i = 0; i < `MCOI_MOTORS; i++) begin
                        check_ctrl_pins(i, expected_pins(i));
                    end
                end
                STEP_TEST_END: begin
                    $display("test %0d (%s) done: %0d checks, %0d errors",
                             rec.motor, test_name[rec.motor], test_checks, test_errors);
                    total_checks += test_checks;
                    total_errors += test_errors;
                    test_checks = 0;
                    test_errors = 0;
                end
                default: begin
                    test_errors++;
                    $display("ERROR trace line %0d has unknown step kind %h", idx, rec.kind);
                end
            endcase
        end
        if (!done) begin
            test_errors++;
            $display("ERROR trace ran out without an end step");
        end
        total_checks += test_checks;
        total_errors += test_errors;
        $display("summary: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0 && total_checks > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/mcoi_trace.txt
// kind_motor _ stimulus frame (op_motor_payload) _ expected (frame, pin word, status or count)
// kinds: 0 end, 1 frame, 2 pin inputs, 4 idle, 5 GET_ALL wait, 6/9 pins, 7 random write, 8 status, e test end
6_0_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0002
6_f_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0002
9_0_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
1_0_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
e_1_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
1_2_1_2_000000_0000_0000_000b_0_0_000000_0000_0000_0000
6_2_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_000b
1_9_1_9_000000_0000_0000_0004_0_0_000000_0000_0000_0000
6_9_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0004
1_f_1_f_000000_0000_0000_0009_0_0_000000_0000_0000_0000
6_f_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0009
7_5_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
7_c_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
7_0_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
9_0_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
e_2_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
1_2_2_2_000000_0000_0000_0000_2_2_000000_0000_0000_000b
1_9_2_9_000000_0000_0000_0000_2_9_000000_0000_0000_0004
1_7_2_7_000000_0000_0000_0000_2_7_000000_0000_0000_0002
1_7_1_7_000000_0000_0000_0003_0_0_000000_0000_0000_0000
1_7_2_7_000000_0000_0000_0000_2_7_000000_0000_0000_0003
1_0_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
1_0_3_0_000000_0000_0000_0000_3_0_000000_0000_0000_0000
e_3_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
2_0_0_0_000000_1000_0040_0002_0_0_000000_0000_0000_0000
5_0_3_0_000000_0000_0000_0000_3_0_000000_1000_0040_0002
9_0_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
8_1_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0002
8_c_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0004
8_6_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0001
2_0_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
5_0_3_0_000000_0000_0000_0000_3_0_000000_0000_0000_0000
2_0_0_0_000000_0000_0400_0010_0_0_000000_0000_0000_0000
4_0_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0005
2_0_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
4_0_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0014
1_0_3_0_000000_0000_0000_0000_3_0_000000_0000_0000_0000
e_4_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
1_3_1_3_000000_0000_0000_0005_0_0_000000_0000_0000_0000
6_3_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0005
2_0_0_0_000000_0000_0000_0008_0_0_000000_0000_0000_0000
5_0_3_0_000000_0000_0000_0000_3_0_000000_0000_0000_0008
6_3_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0004
1_3_2_3_000000_0000_0000_0000_2_3_000000_0000_0000_0025
1_3_1_3_000000_0000_0000_0001_0_0_000000_0000_0000_0000
6_3_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0001
2_0_0_0_000000_0008_0000_0008_0_0_000000_0000_0000_0000
5_0_3_0_000000_0000_0000_0000_3_0_000000_0008_0000_0008
6_3_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
8_3_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0006
1_3_2_3_000000_0000_0000_0000_2_3_000000_0000_0000_0061
9_0_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
e_5_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000
0_0_0_0_000000_0000_0000_0000_0_0_000000_0000_0000_0000

// File: src.f
+incdir+hw
hw/mcoi_pkg.sv
hw/motor_pingroup.sv
hw/mcoi_base.sv
hw/mcoi_xu5_design_complet.sv
sim/tb_mcoi.sv

// File: run.sh
#!/bin/sh
# compile the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -f src.f --top-module tb_mcoi -o tb_mcoi &&
./obj_dir/tb_mcoi | tee /dev/stderr | grep -qx ">>> PASS" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
